// File: verilog/mio_map_pkg.sv
// Address map and timer register layout for the memory and I/O path.
// Regions are assumed not to overlap; the physical range is checked first.
// The internal window is 32 bytes wide, starting at its base.
package mio_map_pkg;

   // Where a load or store ends up
   typedef enum logic [1:0] {
      REG_PHYS   = 2'd0,                       // L1 data cache
      REG_EXT_IO = 2'd1,                       // External I/O port
      REG_INT_IO = 2'd2,                       // Timer registers
      REG_NONE   = 2'd3                        // Unmapped
   } region_t;

   // Internal register being addressed
   typedef enum logic [2:0] {
      SEL_MSIP        = 3'd0,
      SEL_MTIME_LO    = 3'd1,
      SEL_MTIME_HI    = 3'd2,
      SEL_MTIMECMP_LO = 3'd3,
      SEL_MTIMECMP_HI = 3'd4,
      SEL_BAD         = 3'd7                   // Hole in the window
   } clint_sel_t;

   // Byte offsets from the internal I/O base
   localparam logic [4:0]  MSIP_OFS     = 5'd0;
   localparam logic [4:0]  MTIME_OFS    = 5'd8;   // lo word, hi word at +4
   localparam logic [4:0]  MTIMECMP_OFS = 5'd16;  // lo word, hi word at +4

   localparam logic [31:0] INT_IO_SPAN  = 32'd32; // Bytes in the internal window

   // ------------------------------------------------------------------------
   // Default address map
   // ------------------------------------------------------------------------
   localparam logic [31:0] DEF_PHYS_LO     = 32'h0000_0000;
   localparam logic [31:0] DEF_PHYS_HI     = 32'h0003_FFFF;  // 256 KB
   localparam logic [31:0] DEF_EXT_IO_LO   = 32'hC000_0000;
   localparam logic [31:0] DEF_EXT_IO_HI   = 32'hC000_FFFF;
   localparam logic [31:0] DEF_INT_IO_BASE = 32'hFFFF_0000;

endpackage

// File: verilog/mio_types_pkg.sv
// Data types passed between the memory stage, the decoder, the sequencer
// and the cache and I/O ports. Sizes are byte counts (1, 2 or 4).
package mio_types_pkg;

   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;

   // Access size, encoded as the number of bytes
   typedef enum logic [2:0] {
      SZ_BYTE = 3'd1,
      SZ_HALF = 3'd2,
      SZ_WORD = 3'd4
   } size_t;

   // Request from the memory stage, held until ack
   typedef struct packed {
      logic    rd;                             // Load
      logic    wr;                             // Store
      word_t   addr;
      word_t   wr_data;                        // Store data
      size_t   size;
      logic    zero_ext;                       // 1 = zero extend a load
   } mio_req_t;

   // Captured request with its classification
   typedef struct packed {
      mio_req_t                req;
      mio_map_pkg::region_t    region;
      mio_map_pkg::clint_sel_t sel;            // Only meaningful for REG_INT_IO
      logic                    bad;            // Answered with a fault
   } mio_dec_t;

   // Command on the cache or I/O port
   typedef struct packed {
      logic    rd;
      logic    wr;
      word_t   addr;
      word_t   wr_data;
      size_t   size;
      logic    zero_ext;
   } bus_cmd_t;

   // Response back to the memory stage, valid with mio_ack
   typedef struct packed {
      word_t   rd_data;
      logic    fault;
   } mio_rsp_t;

endpackage

// File: verilog/mio_decode.sv
// Input side of the memory and I/O path. Captures one held request at a
// time and keeps it until the sequencer answers with done.
// Internal registers accept word accesses only.
`timescale 1ns/1ns

module mio_decode #(
   parameter logic [31:0] PHYS_LO     = mio_map_pkg::DEF_PHYS_LO,
   parameter logic [31:0] PHYS_HI     = mio_map_pkg::DEF_PHYS_HI,
   parameter logic [31:0] EXT_IO_LO   = mio_map_pkg::DEF_EXT_IO_LO,
   parameter logic [31:0] EXT_IO_HI   = mio_map_pkg::DEF_EXT_IO_HI,
   parameter logic [31:0] INT_IO_BASE = mio_map_pkg::DEF_INT_IO_BASE
) (
   input  logic                    clk_in,
   input  logic                    rst_n,
   input  logic                    mio_req,        // Held until mio_ack
   input  mio_types_pkg::mio_req_t mio_req_data,
   input  logic                    done,           // Response cycle, frees the slot
   output logic                    dec_valid,      // Holding a request
   output mio_types_pkg::mio_dec_t dec
);

   mio_types_pkg::mio_dec_t next_dec;
   mio_types_pkg::word_t    addr;
   logic [31:0]             int_ofs;               // Offset into internal window
   logic [2:0]              int_word;              // Word index in that window
   logic                    misaligned;
   logic                    bad_size;
   logic                    capture;

   assign addr     = mio_req_data.addr;
   assign int_ofs  = addr - INT_IO_BASE;           // Wraps above the window
   assign int_word = int_ofs[4:2];
   assign capture  = mio_req && !dec_valid;

   // ------------------------------------------------------------------------
   // Classification of the incoming request
   // ------------------------------------------------------------------------
   always_comb begin
      next_dec     = '0;
      next_dec.req = mio_req_data;
      misaligned   = 1'b0;
      bad_size     = 1'b0;

      // Alignment by size
      case (mio_req_data.size)
         mio_types_pkg::SZ_BYTE: misaligned = 1'b0;
         mio_types_pkg::SZ_HALF: misaligned = addr[0];
         mio_types_pkg::SZ_WORD: misaligned = |addr[1:0];
         default:                bad_size   = 1'b1;  // Not 1, 2 or 4 bytes
      endcase

      // Region, physical memory first
      if (addr >= PHYS_LO && addr <= PHYS_HI)
         next_dec.region = mio_map_pkg::REG_PHYS;
      else if (addr >= EXT_IO_LO && addr <= EXT_IO_HI)
         next_dec.region = mio_map_pkg::REG_EXT_IO;
      else if (int_ofs < mio_map_pkg::INT_IO_SPAN)
         next_dec.region = mio_map_pkg::REG_INT_IO;
      else
         next_dec.region = mio_map_pkg::REG_NONE;

      // Register within the internal window
      case (int_word)
         mio_map_pkg::MSIP_OFS[4:2]:            next_dec.sel = mio_map_pkg::SEL_MSIP;
         mio_map_pkg::MTIME_OFS[4:2]:           next_dec.sel = mio_map_pkg::SEL_MTIME_LO;
         mio_map_pkg::MTIME_OFS[4:2] + 3'd1:    next_dec.sel = mio_map_pkg::SEL_MTIME_HI;
         mio_map_pkg::MTIMECMP_OFS[4:2]:        next_dec.sel = mio_map_pkg::SEL_MTIMECMP_LO;
         mio_map_pkg::MTIMECMP_OFS[4:2] + 3'd1: next_dec.sel = mio_map_pkg::SEL_MTIMECMP_HI;
         default:                               next_dec.sel = mio_map_pkg::SEL_BAD;
      endcase

      next_dec.bad = misaligned || bad_size
                  || (next_dec.region == mio_map_pkg::REG_NONE)
                  || ((next_dec.region == mio_map_pkg::REG_INT_IO)
                      && ((mio_req_data.size != mio_types_pkg::SZ_WORD)
                          || (next_dec.sel == mio_map_pkg::SEL_BAD)));
   end

   // Occupancy, one request in flight
   always_ff @(posedge clk_in) begin
      if (!rst_n)
         dec_valid <= 1'b0;
      else if (done)
         dec_valid <= 1'b0;                        // Answered this cycle
      else if (capture)
         dec_valid <= 1'b1;
   end

   // Held copy of the request
   always_ff @(posedge clk_in) begin
      if (capture)
         dec <= next_dec;
   end

endmodule

// File: verilog/clint_timer.sv
// Machine timer registers: 64-bit mtime, 64-bit mtimecmp and msip.
// mtime counts clock cycles, not a separate time base.
// Interrupt levels lag the registers by one cycle.
`timescale 1ns/1ns

module clint_timer (
   input  logic                    clk_in,
   input  logic                    rst_n,
   input  logic                    clint_wr,       // Write pulse
   input  mio_map_pkg::clint_sel_t clint_rd_sel,   // Register for read and write
   input  mio_types_pkg::word_t    clint_wr_data,
   output mio_types_pkg::word_t    clint_rd_data,  // Combinational read
   output logic                    timer_irq,
   output logic                    sw_irq
);

   localparam int W = mio_types_pkg::XLEN;

   logic [2*W-1:0] mtime;
   logic [2*W-1:0] mtimecmp;
   logic           msip;                           // Only bit 0 is stored

   // ------------------------------------------------------------------------
   // Register writes
   // ------------------------------------------------------------------------
   // Free running counter; a write replaces one half for this cycle
   always_ff @(posedge clk_in) begin
      if (!rst_n)
         mtime <= '0;
      else if (clint_wr && clint_rd_sel == mio_map_pkg::SEL_MTIME_LO)
         mtime <= {mtime[2*W-1:W], clint_wr_data};
      else if (clint_wr && clint_rd_sel == mio_map_pkg::SEL_MTIME_HI)
         mtime <= {clint_wr_data, mtime[W-1:0]};
      else
         mtime <= mtime + 1'b1;
   end

   // Compare value, all ones keeps the timer interrupt off
   always_ff @(posedge clk_in) begin
      if (!rst_n)
         mtimecmp <= '1;
      else if (clint_wr && clint_rd_sel == mio_map_pkg::SEL_MTIMECMP_LO)
         mtimecmp[W-1:0] <= clint_wr_data;
      else if (clint_wr && clint_rd_sel == mio_map_pkg::SEL_MTIMECMP_HI)
         mtimecmp[2*W-1:W] <= clint_wr_data;
   end

   always_ff @(posedge clk_in) begin
      if (!rst_n)
         msip <= 1'b0;
      else if (clint_wr && clint_rd_sel == mio_map_pkg::SEL_MSIP)
         msip <= clint_wr_data[0];
   end

   // ------------------------------------------------------------------------
   // Read mux
   // ------------------------------------------------------------------------
   always_comb begin
      case (clint_rd_sel)
         mio_map_pkg::SEL_MSIP:        clint_rd_data = {{(W-1){1'b0}}, msip};
         mio_map_pkg::SEL_MTIME_LO:    clint_rd_data = mtime[W-1:0];
         mio_map_pkg::SEL_MTIME_HI:    clint_rd_data = mtime[2*W-1:W];
         mio_map_pkg::SEL_MTIMECMP_LO: clint_rd_data = mtimecmp[W-1:0];
         mio_map_pkg::SEL_MTIMECMP_HI: clint_rd_data = mtimecmp[2*W-1:W];
         default:                      clint_rd_data = '0;  // Holes read as zero
      endcase
   end

   // Interrupt levels
   always_ff @(posedge clk_in) begin
      if (!rst_n) begin
         timer_irq <= 1'b0;
         sw_irq    <= 1'b0;
      end else begin
         timer_irq <= (mtime >= mtimecmp);         // Unsigned 64-bit compare
         sw_irq    <= msip;
      end
   end

endmodule

// File: verilog/mio_sequencer.sv
// Output side of the memory and I/O path. Answers bad and internal accesses
// after one state, runs held req/ack cycles on the cache or I/O port.
// Port commands follow the captured request and stay stable while busy.
`timescale 1ns/1ns

module mio_sequencer (
   input  logic                    clk_in,
   input  logic                    rst_n,
   // From the decoder
   input  logic                    dec_valid,
   input  mio_types_pkg::mio_dec_t dec,
   // Response to the memory stage
   output logic                    done,           // One cycle, same as mio_ack
   output mio_types_pkg::mio_rsp_t mio_rsp,
   // Timer registers
   output logic                    clint_wr,
   output mio_map_pkg::clint_sel_t clint_rd_sel,
   output mio_types_pkg::word_t    clint_wr_data,
   input  mio_types_pkg::word_t    clint_rd_data,
   // L1 data cache port
   output logic                    dc_req,
   output mio_types_pkg::bus_cmd_t dc_cmd,
   input  logic                    dc_ack,
   input  mio_types_pkg::word_t    dc_ack_data,
   // External I/O port
   output logic                    io_req,
   output mio_types_pkg::bus_cmd_t io_cmd,
   input  logic                    io_ack,
   input  logic                    io_ack_fault,
   input  mio_types_pkg::word_t    io_rd_data
);

   typedef enum logic [1:0] {
      ST_IDLE     = 2'd0,
      ST_INT      = 2'd1,                          // Response for bad or internal access
      ST_BUS_WAIT = 2'd2,                          // Port req held, waiting for ack
      ST_RESP     = 2'd3                           // Response for port access
   } seq_state_t;

   seq_state_t              state;
   mio_types_pkg::bus_cmd_t cmd;
   mio_types_pkg::mio_rsp_t rsp_q;
   logic                    start;
   logic                    local_acc;             // No bus cycle needed
   logic                    to_phys;
   logic                    port_ack;

   assign start     = (state == ST_IDLE) && dec_valid;
   assign local_acc = dec.bad || (dec.region == mio_map_pkg::REG_INT_IO);
   assign to_phys   = (dec.region == mio_map_pkg::REG_PHYS);
   assign port_ack  = to_phys ? dc_ack : io_ack;

   // ------------------------------------------------------------------------
   // Port commands
   // ------------------------------------------------------------------------
   always_comb begin
      cmd.rd       = dec.req.rd;
      cmd.wr       = dec.req.wr;
      cmd.addr     = dec.req.addr;
      cmd.wr_data  = dec.req.wr_data;
      cmd.size     = dec.req.size;
      cmd.zero_ext = dec.req.zero_ext;
   end

   assign dc_cmd = cmd;
   assign io_cmd = cmd;
   assign dc_req = (state == ST_BUS_WAIT) && to_phys;
   assign io_req = (state == ST_BUS_WAIT) && !to_phys;

   // Timer access happens on the edge that leaves ST_IDLE
   assign clint_wr      = start && local_acc && !dec.bad && dec.req.wr;
   assign clint_rd_sel  = dec.sel;
   assign clint_wr_data = dec.req.wr_data;

   // ------------------------------------------------------------------------
   // FSM
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (!rst_n) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE:
               if (dec_valid)
                  state <= local_acc ? ST_INT : ST_BUS_WAIT;
            ST_BUS_WAIT:
               if (port_ack)
                  state <= ST_RESP;                // Slow ack keeps us here
            ST_INT,
            ST_RESP:
               state <= ST_IDLE;                   // Decoder frees on done
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   // Response capture
   always_ff @(posedge clk_in) begin
      if (start && dec.bad) begin
         rsp_q.rd_data <= '0;                      // Fault returns zero data
         rsp_q.fault   <= 1'b1;
      end else if (start && local_acc) begin
         rsp_q.rd_data <= dec.req.wr ? '0 : clint_rd_data;
         rsp_q.fault   <= 1'b0;
      end else if ((state == ST_BUS_WAIT) && port_ack) begin
         rsp_q.rd_data <= to_phys ? dc_ack_data : io_rd_data;
         rsp_q.fault   <= to_phys ? 1'b0 : io_ack_fault;  // Cache never faults
      end
   end

   assign done    = (state == ST_INT) || (state == ST_RESP);
   assign mio_rsp = rsp_q;

endmodule

// File: verilog/mmio_core.sv
// Memory and I/O path of the RV32 core with its machine timer.
// One access in flight; the memory stage holds mio_req until mio_ack.
// Internal accesses ack 2 edges after capture, port accesses follow the ack.
`timescale 1ns/1ns

module mmio_core #(
   parameter logic [31:0] PHYS_LO     = mio_map_pkg::DEF_PHYS_LO,
   parameter logic [31:0] PHYS_HI     = mio_map_pkg::DEF_PHYS_HI,
   parameter logic [31:0] EXT_IO_LO   = mio_map_pkg::DEF_EXT_IO_LO,
   parameter logic [31:0] EXT_IO_HI   = mio_map_pkg::DEF_EXT_IO_HI,
   parameter logic [31:0] INT_IO_BASE = mio_map_pkg::DEF_INT_IO_BASE
) (
   input  logic                    clk_in,
   input  logic                    rst_n,
   // Memory stage
   input  logic                    mio_req,
   input  mio_types_pkg::mio_req_t mio_req_data,
   output logic                    mio_ack,
   output mio_types_pkg::mio_rsp_t mio_rsp,
   // L1 data cache
   output logic                    dc_req,
   output mio_types_pkg::bus_cmd_t dc_cmd,
   input  logic                    dc_ack,
   input  mio_types_pkg::word_t    dc_ack_data,
   // External I/O
   output logic                    io_req,
   output mio_types_pkg::bus_cmd_t io_cmd,
   input  logic                    io_ack,
   input  logic                    io_ack_fault,
   input  mio_types_pkg::word_t    io_rd_data,
   // Interrupt levels
   output logic                    timer_irq,
   output logic                    sw_irq
);

   logic                    dec_valid;
   mio_types_pkg::mio_dec_t dec;
   logic                    done;
   logic                    clint_wr;
   mio_map_pkg::clint_sel_t clint_rd_sel;
   mio_types_pkg::word_t    clint_wr_data;
   mio_types_pkg::word_t    clint_rd_data;

   assign mio_ack = done;                          // Response cycle is the ack

   // Capture and classify
   mio_decode #(
      .PHYS_LO(PHYS_LO), .PHYS_HI(PHYS_HI),
      .EXT_IO_LO(EXT_IO_LO), .EXT_IO_HI(EXT_IO_HI),
      .INT_IO_BASE(INT_IO_BASE)
   ) mio_decode_inst (
      .clk_in(clk_in), .rst_n(rst_n),
      .mio_req(mio_req), .mio_req_data(mio_req_data),
      .done(done),
      .dec_valid(dec_valid), .dec(dec)
   );

   // Route to cache, I/O or timer
   mio_sequencer mio_sequencer_inst (
      .clk_in(clk_in), .rst_n(rst_n),
      .dec_valid(dec_valid), .dec(dec),
      .done(done), .mio_rsp(mio_rsp),
      .clint_wr(clint_wr), .clint_rd_sel(clint_rd_sel),
      .clint_wr_data(clint_wr_data), .clint_rd_data(clint_rd_data),
      .dc_req(dc_req), .dc_cmd(dc_cmd), .dc_ack(dc_ack), .dc_ack_data(dc_ack_data),
      .io_req(io_req), .io_cmd(io_cmd), .io_ack(io_ack),
      .io_ack_fault(io_ack_fault), .io_rd_data(io_rd_data)
   );

   // Timer and software interrupt registers
   clint_timer clint_timer_inst (
      .clk_in(clk_in), .rst_n(rst_n),
      .clint_wr(clint_wr), .clint_rd_sel(clint_rd_sel),
      .clint_wr_data(clint_wr_data), .clint_rd_data(clint_rd_data),
      .timer_irq(timer_irq), .sw_irq(sw_irq)
   );

endmodule

// File: verif/tb_clk_gen.sv
// Testbench clock and reset source. 20 ns period, reset low for 3 edges.
// Reset is released 1 ns after the third rising edge.
`timescale 1ns/1ns

module tb_clk_gen (
   output logic clk_in,
   output logic rst_n
);

   // 50 MHz clock
   initial begin
      clk_in = 1'b0;
      forever #10 clk_in = ~clk_in;
   end

   initial begin
      rst_n = 1'b0;                                // Synchronous, active low
      repeat (3) @(posedge clk_in);
      #1 rst_n = 1'b1;
   end

endmodule

// File: verif/mmio_core_tb.sv
// Testbench for the memory and I/O path with its machine timer.
// Vectors come from verif/mmio_core_vectors.txt, first word is the count.
// Inputs change 1 ns after a rising edge, outputs are sampled on falling edges.
// One port responder serves both the cache and the I/O port.
`timescale 1ns/1ns

module mmio_core_tb;

   localparam int MAX_VECS = 64;
   localparam int VEC_COLS = 12;                   // Fields per vector line

   logic                    clk_in;
   logic                    rst_n;
   logic                    mio_req;
   mio_types_pkg::mio_req_t mio_req_data;
   logic                    mio_ack;
   mio_types_pkg::mio_rsp_t mio_rsp;
   logic                    dc_req;
   mio_types_pkg::bus_cmd_t dc_cmd;
   logic                    dc_ack;
   mio_types_pkg::word_t    dc_ack_data;
   logic                    io_req;
   mio_types_pkg::bus_cmd_t io_cmd;
   logic                    io_ack;
   logic                    io_ack_fault;
   mio_types_pkg::word_t    io_rd_data;
   logic                    timer_irq;
   logic                    sw_irq;

   logic [31:0] vec_mem [0:MAX_VECS*VEC_COLS];    // Count word, then the vectors
   int          vec_count;
   int          max_lat;
   int          watch_cycles;
   logic        limit_ready;

   // Fields of the vector under test
   logic [31:0] cur_op, cur_addr, cur_size, cur_zext, cur_wr_data, cur_lat;
   logic [31:0] cur_rsp_data, cur_rsp_fault, cur_port;
   logic [31:0] cur_exp_data, cur_exp_fault, cur_exp_irq;

   logic                    dc_seen;               // Port req raised in this test
   logic                    io_seen;
   logic                    ack_given;             // Responder has acked
   logic                    use_dc;
   mio_types_pkg::bus_cmd_t held_cmd;             // Command as first seen

   int errors;
   int tests_run;
   int tests_failed;

   tb_clk_gen clk_gen_inst (.clk_in(clk_in), .rst_n(rst_n));

   mmio_core mmio_core_inst (
      .clk_in(clk_in), .rst_n(rst_n),
      .mio_req(mio_req), .mio_req_data(mio_req_data),
      .mio_ack(mio_ack), .mio_rsp(mio_rsp),
      .dc_req(dc_req), .dc_cmd(dc_cmd), .dc_ack(dc_ack), .dc_ack_data(dc_ack_data),
      .io_req(io_req), .io_cmd(io_cmd), .io_ack(io_ack),
      .io_ack_fault(io_ack_fault), .io_rd_data(io_rd_data),
      .timer_irq(timer_irq), .sw_irq(sw_irq)
   );

   // ------------------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------------------
   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      assert (actual === expected)
      else begin
         $display("Error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic expect_true(input logic cond, input string what);
      assert (cond === 1'b1)
      else begin
         $display("Failure at %0t ns: %s", $time, what);
         errors++;
      end
   endtask

   // Port command against the vector's request
   task automatic check_command(input string port, input mio_types_pkg::bus_cmd_t cmd);
      compare_value({port, ".addr"}, cur_addr, cmd.addr);
      compare_value({port, ".size"}, cur_size, cmd.size);
      compare_value({port, ".zero_ext"}, cur_zext, cmd.zero_ext);
      compare_value({port, ".wr_data"}, cur_wr_data, cmd.wr_data);
      compare_value({port, ".rd_wr"}, {cur_op == 0, cur_op != 0}, {cmd.rd, cmd.wr});
   endtask

   // ------------------------------------------------------------------------
   // Vector file
   // ------------------------------------------------------------------------
   task automatic read_vectors();
      int i;
      $readmemh("verif/mmio_core_vectors.txt", vec_mem);
      vec_count = 0;
      max_lat   = 0;
      if ($isunknown(vec_mem[0]) || vec_mem[0] > MAX_VECS || vec_mem[0] == 0) begin
         expect_true(1'b0, "vector file is missing or its count is out of range");
      end else if ($isunknown(vec_mem[vec_mem[0]*VEC_COLS])) begin
         expect_true(1'b0, "vector file holds fewer vectors than its count");
      end else begin
         vec_count = vec_mem[0];
         for (i = 0; i < vec_count; i++)
            if (vec_mem[1 + i*VEC_COLS + 5] > max_lat)
               max_lat = vec_mem[1 + i*VEC_COLS + 5];
      end
   endtask

   task automatic load_vector(input int idx);
      int base;
      base          = 1 + idx*VEC_COLS;
      cur_op        = vec_mem[base];               // 0 load, 1 store
      cur_addr      = vec_mem[base + 1];
      cur_size      = vec_mem[base + 2];
      cur_zext      = vec_mem[base + 3];
      cur_wr_data   = vec_mem[base + 4];
      cur_lat       = vec_mem[base + 5];
      cur_rsp_data  = vec_mem[base + 6];
      cur_rsp_fault = vec_mem[base + 7];
      cur_port      = vec_mem[base + 8];           // 0 none, 1 cache, 2 I/O
      cur_exp_data  = vec_mem[base + 9];
      cur_exp_fault = vec_mem[base + 10];
      cur_exp_irq   = vec_mem[base + 11];          // Bit 0 timer, bit 1 software
   endtask

   // ------------------------------------------------------------------------
   // One access from drive to response
   // ------------------------------------------------------------------------
   task automatic run_test(input int idx);
      int   err_start;
      int   cycles;
      logic got_ack;
      load_vector(idx);
      err_start = errors;
      dc_seen   = 1'b0;
      io_seen   = 1'b0;
      ack_given = 1'b0;
      @(posedge clk_in);
      #1;
      mio_req               = 1'b1;                // Held until mio_ack
      mio_req_data.rd       = (cur_op == 0);
      mio_req_data.wr       = (cur_op != 0);
      mio_req_data.addr     = cur_addr;
      mio_req_data.wr_data  = cur_wr_data;
      mio_req_data.size     = mio_types_pkg::size_t'(cur_size[2:0]);
      mio_req_data.zero_ext = cur_zext[0];
      cycles  = 0;
      got_ack = 1'b0;
      while (!got_ack && cycles < max_lat + 8) begin
         @(negedge clk_in);
         cycles++;
         got_ack = mio_ack;
      end
      expect_true(got_ack, "no mio_ack arrived for this access");
      if (got_ack) begin
         compare_value("mio_rsp.rd_data", cur_exp_data, mio_rsp.rd_data);
         compare_value("mio_rsp.fault", cur_exp_fault, mio_rsp.fault);
         if (cur_port == 0)
            compare_value("mio_ack latency in edges", 2, cycles - 1);
         else begin
            expect_true(ack_given, "mio_ack came before the port ack");
            // Capture, port req, responder wait, ack edge, then mio_ack
            compare_value("mio_ack latency in edges", cur_lat + 3, cycles - 1);
         end
      end
      @(posedge clk_in);
      #1;
      mio_req      = 1'b0;                         // Drop after the ack edge
      mio_req_data = '0;
      @(negedge clk_in);                           // Irq levels settled by now
      compare_value("dc_req raised", cur_port == 1, dc_seen);
      compare_value("io_req raised", cur_port == 2, io_seen);
      compare_value("timer_irq", cur_exp_irq[0], timer_irq);
      compare_value("sw_irq", cur_exp_irq[1], sw_irq);
      tests_run++;
      if (errors != err_start)
         tests_failed++;
      $display("test %0d %s addr %h size %0d: %s", idx, cur_op[0] ? "store" : "load",
               cur_addr, cur_size, (errors == err_start) ? "ok" : "mismatch");
   endtask

   // Cache and I/O responder, waits the vector's latency then acks
   always begin
      @(posedge clk_in);
      #1;
      if (dc_req || io_req) begin
         use_dc   = dc_req;
         held_cmd = dc_req ? dc_cmd : io_cmd;
         if (dc_req)
            dc_seen = 1'b1;
         if (io_req)
            io_seen = 1'b1;                        // Both flagged if both are up
         check_command(use_dc ? "dc_cmd" : "io_cmd", held_cmd);
         repeat (cur_lat) begin
            @(posedge clk_in);
            #1;
            expect_true(use_dc ? dc_req : io_req, "port req dropped before its ack");
            expect_true((use_dc ? dc_cmd : io_cmd) === held_cmd,
                        "port command changed while its req was high");
         end
         if (use_dc) begin
            dc_ack      = 1'b1;
            dc_ack_data = cur_rsp_data;
         end else begin
            io_ack       = 1'b1;
            io_rd_data   = cur_rsp_data;
            io_ack_fault = cur_rsp_fault[0];
         end
         ack_given = 1'b1;
         @(posedge clk_in);
         #1;
         dc_ack       = 1'b0;                      // One cycle ack
         dc_ack_data  = '0;
         io_ack       = 1'b0;
         io_rd_data   = '0;
         io_ack_fault = 1'b0;
      end
   end

   // Watchdog, sized from the vectors once they are read
   initial begin
      wait (limit_ready === 1'b1);
      repeat (watch_cycles) @(posedge clk_in);
      $display("Timeout after %0d cycles, the DUT stopped answering", watch_cycles);
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      limit_ready  = 1'b0;
      mio_req      = 1'b0;
      mio_req_data = '0;
      dc_ack       = 1'b0;
      dc_ack_data  = '0;
      io_ack       = 1'b0;
      io_ack_fault = 1'b0;
      io_rd_data   = '0;
      dc_seen      = 1'b0;
      io_seen      = 1'b0;
      ack_given    = 1'b0;
      cur_lat      = '0;
      read_vectors();
      watch_cycles = vec_count * (max_lat + 4) + 10;
      limit_ready  = 1'b1;
      wait (rst_n === 1'b1);
      for (int i = 0; i < vec_count; i++)
         run_test(i);
      $display("%0d tests run, %0d passed, %0d failed, %0d errors",
               tests_run, tests_run - tests_failed, tests_failed, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// File: mmio_core.f
verilog/mio_map_pkg.sv
verilog/mio_types_pkg.sv
verilog/mio_decode.sv
verilog/clint_timer.sv
verilog/mio_sequencer.sv
verilog/mmio_core.sv
verif/tb_clk_gen.sv
verif/mmio_core_tb.sv

// File: verif/mmio_core_vectors.txt
// All fields hex. First word is the vector count, then one access per line
// op(0 load 1 store) addr size zext wr_data lat rsp_data rsp_fault
// port(0 none 1 cache 2 io) exp_data exp_fault exp_irq(bit0 timer bit1 sw)
0000001A
0 00000100 4 0 00000000 0 DEADBEEF 0 1 DEADBEEF 0 0
0 00000203 1 1 00000000 2 000000A5 0 1 000000A5 0 0
1 00010002 2 0 0000BEEF 3 00000000 0 1 00000000 0 0
0 0003FFFC 4 0 00000000 6 12345678 0 1 12345678 0 0
0 00000010 2 0 00000000 6 FFFF8000 0 1 FFFF8000 0 0
0 C0000010 4 0 00000000 1 CAFEF00D 0 2 CAFEF00D 0 0
1 C0000020 4 0 A5A55A5A 4 00000000 0 2 00000000 0 0
0 C000FFFC 4 0 00000000 2 00000000 1 2 00000000 1 0
0 C0000006 2 1 00000000 5 0000BEEF 0 2 0000BEEF 0 0
0 FFFF000C 4 0 00000000 0 00000000 0 0 00000000 0 0
1 FFFF0010 4 0 12345678 0 00000000 0 0 00000000 0 0
1 FFFF0014 4 0 000000AB 0 00000000 0 0 00000000 0 0
0 FFFF0010 4 0 00000000 0 00000000 0 0 12345678 0 0
0 FFFF0014 4 0 00000000 0 00000000 0 0 000000AB 0 0
1 FFFF0014 4 0 00000000 0 00000000 0 0 00000000 0 0
1 FFFF0010 4 0 00000000 0 00000000 0 0 00000000 0 1
0 FFFF0010 4 0 00000000 0 00000000 0 0 00000000 0 1
1 FFFF0014 4 0 FFFFFFFF 0 00000000 0 0 00000000 0 0
1 FFFF0000 4 0 00000001 0 00000000 0 0 00000000 0 2
0 FFFF0000 4 0 00000000 0 00000000 0 0 00000001 0 2
1 FFFF0000 4 0 00000000 0 00000000 0 0 00000000 0 0
0 00000101 2 0 00000000 0 00000000 0 0 00000000 1 0
0 FFFF0000 1 0 00000000 0 00000000 0 0 00000000 1 0
0 80000000 4 0 00000000 0 00000000 0 0 00000000 1 0
0 FFFF0004 4 0 00000000 0 00000000 0 0 00000000 1 0
1 C0000002 4 0 000000A5 0 00000000 0 0 00000000 1 0
